// File: ioCmdCtrl.sv
// ioCmdCtrl: command decode, writeback port arbitration and the sticky overflow flag
`timescale 1ns/1ps

module ioCmdCtrl import ioCmdPkg::*; (
    input  logic                   sys_clk,
    input  logic                   arstN,
    input  logic                   cmdStrobe,
    input  logic [3:0]             cmdOpcode,
    input  logic [regWidth-1:0]    cmdDestReg,
    input  logic [dataWidth-1:0]   loadData,
    input  logic                   storeFull,
    input  logic [storeCountW-1:0] storeCount,
    input  logic                   respValid,
    input  logic [regWidth-1:0]    respDestReg,
    input  logic [dataWidth-1:0]   respData,
    input  logic                   respDropped,
    output logic                   storePush,
    output logic                   respPop,
    output logic                   wbStrobe,
    output logic [regWidth-1:0]    wbDestReg,
    output logic [dataWidth-1:0]   wbData,
    output logic                   overflow
);

    cmdClassE             cmdClass;
    logic                 isQueued;
    logic                 isStatus;
    logic                 loadWb;
    logic                 storeDrop;
    logic [regWidth-1:0]  nextDest;
    logic [dataWidth-1:0] nextData;

    assign cmdClass = opClass(cmdOpcode);

    // stores and atomics head for the outgoing queue
    assign isQueued = cmdStrobe && (cmdClass == classStore || cmdClass == classAtomic);
    assign isStatus = cmdStrobe && (cmdClass == classStatus);

    // loads and status loads both claim the writeback slot
    assign loadWb = isStatus || (cmdStrobe && cmdClass == classLoad);

    // nothing stalls the core, so a store into a full queue is lost
    assign storePush = isQueued && !storeFull;
    assign storeDrop = isQueued && storeFull;

    // register responses only get the slot when no load wants it
    assign respPop = respValid && !loadWb;

    // pick the source of the next writeback
    always_comb begin
        if (loadWb) begin
            nextDest = cmdDestReg;
            if (isStatus) begin
                // status load reports the outgoing queue fill level
                nextData = {{(dataWidth - storeCountW){1'b0}}, storeCount};
            end else begin
                nextData = loadData;
            end
        end else begin
            nextDest = respDestReg;
            nextData = respData;
        end
    end

    // writeback strobe and overflow flag
    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            wbStrobe <= 1'b0;
            overflow <= 1'b0;
        end else begin
            wbStrobe <= loadWb || respPop;
            // sticky until reset
            if (storeDrop || respDropped) begin
                overflow <= 1'b1;
            end
        end
    end

    // writeback payload, only meaningful alongside wbStrobe
    always_ff @(posedge sys_clk) begin
        if (loadWb || respPop) begin
            wbDestReg <= nextDest;
            wbData    <= nextData;
        end
    end

endmodule

// File: ioCmdPkg.sv
// ioCmd package: widths, queue depths and opcode decode types for the IO port command controller
package ioCmdPkg;

    // io port word and core data widths
    localparam int portWidth = 32;
    localparam int dataWidth = 16;
    localparam int laneCount = portWidth / 8;

    // core register index width
    localparam int regWidth = 4;

    // outgoing command queue sizing
    localparam int storeDepth  = 8;
    localparam int storePtrW   = $clog2(storeDepth);
    localparam int storeCountW = $clog2(storeDepth + 1);

    // register response queue sizing
    localparam int respDepth  = 4;
    localparam int respPtrW   = $clog2(respDepth);
    localparam int respCountW = $clog2(respDepth + 1);

    // opcode bits 3..2
    typedef enum logic [1:0] {
        classLoad   = 2'b00,
        classStore  = 2'b01,
        classAtomic = 2'b10,
        classStatus = 2'b11
    } cmdClassE;

    // opcode bits 1..0, encoding 11 folds into a word access
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } accessSizeE;

    function automatic cmdClassE opClass(input logic [3:0] opcode);
        return cmdClassE'(opcode[3:2]);
    endfunction

    function automatic accessSizeE opSize(input logic [3:0] opcode);
        accessSizeE size;
        case (opcode[1:0])
            2'b00:   size = sizeByte;
            2'b01:   size = sizeHalf;
            default: size = sizeWord;
        endcase
        return size;
    endfunction

endpackage

// File: ioLoadBuffer.sv
// ioLoadBuffer: holds the last device data response and aligns it for core loads
`timescale 1ns/1ps

module ioLoadBuffer import ioCmdPkg::*; (
    input  logic                 sys_clk,
    input  logic                 arstN,
    input  logic                 ioInStrobe,
    input  logic                 ioInRegFlag,
    input  logic [portWidth-1:0] ioInData,
    input  logic [3:0]           cmdOpcode,
    input  logic [dataWidth-1:0] cmdAddr,
    output logic [dataWidth-1:0] loadData
);

    logic [portWidth-1:0] loadBuf;
    logic [portWidth-1:0] shifted;

    // only data responses touch the buffer, register responses go elsewhere
    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            loadBuf <= '0;
        end else if (ioInStrobe && !ioInRegFlag) begin
            loadBuf <= ioInData;
        end
    end

    // bring the addressed byte down to lane 0
    assign shifted = loadBuf >> {cmdAddr[1:0], 3'b000};

    // read side is purely combinational
    always_comb begin
        case (opSize(cmdOpcode))
            sizeByte: begin
                loadData = {{(dataWidth - 8){1'b0}}, shifted[7:0]};
            end
            sizeHalf: begin
                loadData = cmdAddr[1] ? loadBuf[portWidth-1:dataWidth] : loadBuf[dataWidth-1:0];
            end
            default: begin
                // word loads keep the low half
                loadData = loadBuf[dataWidth-1:0];
            end
        endcase
    end

endmodule

// File: ioPortModel.svh
// ioPortModel: cycle model of the IO port queues, load buffer and writeback priority, plus the LFSR
`ifndef IO_PORT_MODEL_SVH
`define IO_PORT_MODEL_SVH

logic [31:0] lfsrState;

// expected state, entries packed as {atomic, dest, byteEn, data}
logic [40:0] storeModel[$];
logic [19:0] respModel[$];
logic [31:0] bufModel;
logic        expWb;
logic [3:0]  expWbDest;
logic [15:0] expWbData;
logic        expOut;
logic [40:0] expOutEntry;
logic        expOverflow;

// galois lfsr, one step per bit taken
function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    logic        outBit;
    int          i;
    value = '0;
    for (i = 0; i < count; i++) begin
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        value = {value[30:0], outBit};
    end
    return value;
endfunction

// store lane placement by size and low address bits
function automatic logic [40:0] placeStore(input logic [3:0] op, input logic [15:0] addr,
                                           input logic [15:0] data, input logic [3:0] dest);
    logic [3:0]  en;
    logic [31:0] word;
    // word and the 11 encoding fill the low half only
    en   = 4'b0011;
    word = {16'h0000, data};
    if (op[1:0] == 2'b00) begin
        en   = 4'b0001 << addr[1:0];
        word = {24'h000000, data[7:0]} << (8 * addr[1:0]);
    end else if (op[1:0] == 2'b01 && addr[1]) begin
        en   = 4'b1100;
        word = {data, 16'h0000};
    end
    return {(op[3:2] == 2'b10), dest, en, word};
endfunction

// load extraction from the buffer, zero extended
function automatic logic [15:0] extractLoad(input logic [3:0] op, input logic [15:0] addr);
    if (op[1:0] == 2'b00) begin
        return {8'h00, bufModel[8 * addr[1:0] +: 8]};
    end else if (op[1:0] == 2'b01) begin
        return addr[1] ? bufModel[31:16] : bufModel[15:0];
    end
    return bufModel[15:0];
endfunction

// advance one cycle from the inputs applied in this cycle
task automatic modelStep();
    int          oldStore;
    int          oldResp;
    logic        loadWb;
    logic        isQueued;
    logic [19:0] head;
    oldStore = storeModel.size();
    oldResp  = respModel.size();
    loadWb   = cmdStrobe && (cmdOpcode[3:2] == 2'b00 || cmdOpcode[3:2] == 2'b11);
    isQueued = cmdStrobe && (cmdOpcode[3:2] == 2'b01 || cmdOpcode[3:2] == 2'b10);
    expWb    = 1'b0;
    if (loadWb) begin
        expWb     = 1'b1;
        expWbDest = cmdDestReg;
        // status load sees the queue level before this cycle
        expWbData = (cmdOpcode[3:2] == 2'b11) ? 16'(oldStore) : extractLoad(cmdOpcode, cmdAddr);
    end else if (oldResp > 0) begin
        head      = respModel.pop_front();
        expWb     = 1'b1;
        expWbDest = head[19:16];
        expWbData = head[15:0];
    end
    // credit on an empty queue is lost
    expOut = ioOutCredit && (oldStore > 0);
    if (expOut) begin
        expOutEntry = storeModel.pop_front();
    end
    if (isQueued) begin
        if (oldStore == storeDepth) begin
            expOverflow = 1'b1;
        end else begin
            storeModel.push_back(placeStore(cmdOpcode, cmdAddr, cmdData, cmdDestReg));
        end
    end
    if (ioInStrobe && ioInRegFlag) begin
        if (oldResp == respDepth) begin
            expOverflow = 1'b1;
        end else begin
            respModel.push_back({ioInDestReg, ioInData[15:0]});
        end
    end
    if (ioInStrobe && !ioInRegFlag) begin
        bufModel = ioInData;
    end
endtask

`endif

// File: ioPortTb.sv
// random stimulus testbench that checks the IO port command controller against a cycle model
`timescale 1ns/1ps

module ioPortTb import ioCmdPkg::*; ();

    logic        sys_clk;
    logic        arstN;
    logic        cmdStrobe;
    logic [3:0]  cmdOpcode;
    logic [15:0] cmdAddr;
    logic [15:0] cmdData;
    logic [3:0]  cmdDestReg;
    logic        ioOutCredit;
    logic        ioInStrobe;
    logic        ioInRegFlag;
    logic [3:0]  ioInDestReg;
    logic [31:0] ioInData;
    logic        wbStrobe;
    logic [3:0]  wbDestReg;
    logic [15:0] wbData;
    logic        overflow;
    logic        ioOutStrobe;
    logic        ioOutAtomic;
    logic [3:0]  ioOutDestReg;
    logic [3:0]  ioOutByteEn;
    logic [31:0] ioOutData;

    string curTest;
    int    testErrors;
    int    passCount;
    int    failCount;

    `include "ioPortModel.svh"

    ioPortTop ioPortTop_inst (.*);

    always #10 sys_clk = ~sys_clk;

    task automatic reportMismatch(input string what, input logic [40:0] expected,
                                  input logic [40:0] actual);
        $display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, expected, actual);
        testErrors++;
    endtask

    // outputs now hold what the previous cycle's inputs produced
    task automatic checkOutputs();
        assert (wbStrobe === expWb) else reportMismatch("wbStrobe", 41'(expWb), 41'(wbStrobe));
        if (expWb) begin
            assert (wbDestReg === expWbDest)
                else reportMismatch("wbDestReg", 41'(expWbDest), 41'(wbDestReg));
            assert (wbData === expWbData)
                else reportMismatch("wbData", 41'(expWbData), 41'(wbData));
        end
        assert (ioOutStrobe === expOut)
            else reportMismatch("ioOutStrobe", 41'(expOut), 41'(ioOutStrobe));
        if (expOut) begin
            assert ({ioOutAtomic, ioOutDestReg, ioOutByteEn, ioOutData} === expOutEntry)
                else reportMismatch("ioOut entry", expOutEntry,
                                    {ioOutAtomic, ioOutDestReg, ioOutByteEn, ioOutData});
        end
        assert (overflow === expOverflow)
            else reportMismatch("overflow", 41'(expOverflow), 41'(overflow));
    endtask

    // drive one cycle on the rising edge, then check and step the model mid-cycle
    task automatic driveCycle(input logic cs, input logic [3:0] op, input logic [15:0] addr,
                              input logic [15:0] data, input logic credit, input logic inStb,
                              input logic regFlag, input logic [31:0] inData);
        @(posedge sys_clk);
        cmdStrobe   <= cs;
        cmdOpcode   <= op;
        cmdAddr     <= addr;
        cmdData     <= data;
        cmdDestReg  <= 4'(randBits(4));
        ioOutCredit <= credit;
        ioInStrobe  <= inStb;
        ioInRegFlag <= regFlag;
        ioInDestReg <= 4'(randBits(4));
        ioInData    <= inData;
        @(negedge sys_clk);
        checkOutputs();
        modelStep();
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, 4'h0, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok", curTest);
        end else begin
            failCount++;
            $display("test %s: %0d errors", curTest, testErrors);
        end
    endtask

    initial begin
        logic [3:0] op;
        int         i;
        int         j;
        int         waitCount;
        logic       drained;
        sys_clk     = 1'b0;
        arstN       = 1'b0;
        cmdStrobe   = 1'b0;
        cmdOpcode   = 4'h0;
        cmdAddr     = 16'h0000;
        cmdData     = 16'h0000;
        cmdDestReg  = 4'h0;
        ioOutCredit = 1'b0;
        ioInStrobe  = 1'b0;
        ioInRegFlag = 1'b0;
        ioInDestReg = 4'h0;
        ioInData    = 32'h0;
        lfsrState   = 32'h6273;
        bufModel    = 32'h0;
        expWb       = 1'b0;
        expOut      = 1'b0;
        expOverflow = 1'b0;
        passCount   = 0;
        failCount   = 0;
        for (i = 0; i < 8; i++) begin
            @(posedge sys_clk);
        end
        arstN <= 1'b1;

        // idle outputs after reset and zero from status and byte loads of an empty buffer
        startTest("reset");
        idleCycle();
        driveCycle(1'b1, {classStatus, sizeWord}, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 32'h0);
        driveCycle(1'b1, {classLoad, sizeByte}, 16'(randBits(16)), 16'h0, 1'b0, 1'b0, 1'b0,
                   32'h0);
        idleCycle();
        finishTest();

        // queue kept short so no store is dropped here
        startTest("store lanes");
        driveCycle(1'b0, 4'h0, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0, 32'h0);
        for (i = 0; i < 60; i++) begin
            op = randBits(1) ? {classAtomic, 2'(randBits(2))} : {classStore, 2'(randBits(2))};
            driveCycle(randBits(1) && storeModel.size() < 6, op, 16'(randBits(16)),
                       16'(randBits(16)), randBits(2) == 32'd0, 1'b0, 1'b0, 32'h0);
        end
        // credit every cycle until a credit brings no strobe back
        waitCount = 0;
        drained   = 1'b0;
        while (!drained && waitCount < 20) begin
            driveCycle(1'b0, 4'h0, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0, 32'h0);
            // strobe now reflects the previous credit
            drained = (waitCount > 0) && (ioOutStrobe !== 1'b1);
            waitCount++;
        end
        if (!drained) begin
            $display("timeout in %s: outgoing queue never drained", curTest);
            testErrors++;
        end
        driveCycle(1'b0, 4'h0, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0, 32'h0);
        idleCycle();
        finishTest();

        // each data response followed by loads of random size and address
        startTest("load align");
        for (i = 0; i < 30; i++) begin
            driveCycle(1'b0, 4'h0, 16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0, randBits(32));
            for (j = 0; j < 4; j++) begin
                driveCycle(1'b1, {classLoad, 2'(randBits(2))}, 16'(randBits(16)), 16'h0000,
                           1'b0, 1'b0, 1'b0, 32'h0);
            end
        end
        idleCycle();
        finishTest();

        // register responses compete with dense loads for the writeback slot
        startTest("writeback arbitration");
        for (i = 0; i < 80; i++) begin
            driveCycle(randBits(2) != 32'd0, {classLoad, 2'(randBits(2))}, 16'(randBits(16)),
                       16'h0000, 1'b0, randBits(1) && respModel.size() < 3, 1'b1, randBits(32));
        end
        // idle until a cycle with no load passes without a writeback
        waitCount = 0;
        drained   = 1'b0;
        while (!drained && waitCount < 20) begin
            idleCycle();
            drained = (waitCount > 0) && (wbStrobe !== 1'b1);
            waitCount++;
        end
        if (!drained) begin
            $display("timeout in %s: register responses never written back", curTest);
            testErrors++;
        end
        idleCycle();
        finishTest();

        // ten stores with no credits and a status load after each
        startTest("overflow");
        for (i = 0; i < 10; i++) begin
            driveCycle(1'b1, {classStore, 2'(randBits(2))}, 16'(randBits(16)),
                       16'(randBits(16)), 1'b0, 1'b0, 1'b0, 32'h0);
            driveCycle(1'b1, {classStatus, sizeWord}, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0,
                       32'h0);
        end
        idleCycle();
        assert (overflow === 1'b1) else reportMismatch("overflow set", 41'(1), 41'(overflow));
        finishTest();

        $display("tests run %0d, passed %0d, failed %0d", passCount + failCount, passCount,
                 failCount);
        if (failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: ioPortTop.f
+incdir+.
ioCmdPkg.sv
ioCmdCtrl.sv
ioStoreQueue.sv
ioLoadBuffer.sv
ioResponseQueue.sv
ioPortTop.sv
ioPortTb.sv

// File: ioPortTop.sv
// ioPortTop: IO port command controller built from the control block and three datapath blocks
`timescale 1ns/1ps

module ioPortTop import ioCmdPkg::*; (
    input  logic                 sys_clk,
    input  logic                 arstN,
    // core command side
    input  logic                 cmdStrobe,
    input  logic [3:0]           cmdOpcode,
    input  logic [dataWidth-1:0] cmdAddr,
    input  logic [dataWidth-1:0] cmdData,
    input  logic [regWidth-1:0]  cmdDestReg,
    // core writeback side
    output logic                 wbStrobe,
    output logic [regWidth-1:0]  wbDestReg,
    output logic [dataWidth-1:0] wbData,
    output logic                 overflow,
    // device responses
    input  logic                 ioOutCredit,
    input  logic                 ioInStrobe,
    input  logic                 ioInRegFlag,
    input  logic [regWidth-1:0]  ioInDestReg,
    input  logic [portWidth-1:0] ioInData,
    // device commands
    output logic                 ioOutStrobe,
    output logic                 ioOutAtomic,
    output logic [regWidth-1:0]  ioOutDestReg,
    output logic [laneCount-1:0] ioOutByteEn,
    output logic [portWidth-1:0] ioOutData
);

    logic                   storePush;
    logic                   storeFull;
    logic [storeCountW-1:0] storeCount;
    logic [dataWidth-1:0]   loadData;
    logic                   respPop;
    logic                   respValid;
    logic [regWidth-1:0]    respDestReg;
    logic [dataWidth-1:0]   respData;
    logic                   respDropped;

    ioCmdCtrl cmdCtrlInst (
        .sys_clk    (sys_clk),
        .arstN      (arstN),
        .cmdStrobe  (cmdStrobe),
        .cmdOpcode  (cmdOpcode),
        .cmdDestReg (cmdDestReg),
        .loadData   (loadData),
        .storeFull  (storeFull),
        .storeCount (storeCount),
        .respValid  (respValid),
        .respDestReg(respDestReg),
        .respData   (respData),
        .respDropped(respDropped),
        .storePush  (storePush),
        .respPop    (respPop),
        .wbStrobe   (wbStrobe),
        .wbDestReg  (wbDestReg),
        .wbData     (wbData),
        .overflow   (overflow)
    );

    ioStoreQueue storeQueueInst (
        .sys_clk     (sys_clk),
        .arstN       (arstN),
        .storePush   (storePush),
        .cmdOpcode   (cmdOpcode),
        .cmdAddr     (cmdAddr),
        .cmdData     (cmdData),
        .cmdDestReg  (cmdDestReg),
        .ioOutCredit (ioOutCredit),
        .storeFull   (storeFull),
        .storeCount  (storeCount),
        .ioOutStrobe (ioOutStrobe),
        .ioOutAtomic (ioOutAtomic),
        .ioOutDestReg(ioOutDestReg),
        .ioOutByteEn (ioOutByteEn),
        .ioOutData   (ioOutData)
    );

    ioLoadBuffer loadBufferInst (
        .sys_clk    (sys_clk),
        .arstN      (arstN),
        .ioInStrobe (ioInStrobe),
        .ioInRegFlag(ioInRegFlag),
        .ioInData   (ioInData),
        .cmdOpcode  (cmdOpcode),
        .cmdAddr    (cmdAddr),
        .loadData   (loadData)
    );

    ioResponseQueue respQueueInst (
        .sys_clk    (sys_clk),
        .arstN      (arstN),
        .ioInStrobe (ioInStrobe),
        .ioInRegFlag(ioInRegFlag),
        .ioInDestReg(ioInDestReg),
        .ioInData   (ioInData),
        .respPop    (respPop),
        .respValid  (respValid),
        .respDestReg(respDestReg),
        .respData   (respData),
        .respDropped(respDropped)
    );

endmodule

// File: ioResponseQueue.sv
// ioResponseQueue: buffers device register responses until the writeback port is free
`timescale 1ns/1ps

module ioResponseQueue import ioCmdPkg::*; (
    input  logic                 sys_clk,
    input  logic                 arstN,
    input  logic                 ioInStrobe,
    input  logic                 ioInRegFlag,
    input  logic [regWidth-1:0]  ioInDestReg,
    input  logic [portWidth-1:0] ioInData,
    input  logic                 respPop,
    output logic                 respValid,
    output logic [regWidth-1:0]  respDestReg,
    output logic [dataWidth-1:0] respData,
    output logic                 respDropped
);

    logic [respPtrW-1:0]   wrPtr;
    logic [respPtrW-1:0]   rdPtr;
    logic [respCountW-1:0] count;
    logic                  arrive;
    logic                  full;
    logic                  push;

    logic [regWidth-1:0]  memDest [respDepth];
    logic [dataWidth-1:0] memData [respDepth];

    assign arrive = ioInStrobe && ioInRegFlag;
    assign full   = (count == respCountW'(respDepth));

    // fullness is judged on arrival, a same-cycle pop does not make room
    assign push        = arrive && !full;
    assign respDropped = arrive && full;

    assign respValid   = (count != '0);
    assign respDestReg = memDest[rdPtr];
    assign respData    = memData[rdPtr];

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (respPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !respPop) begin
                count <= count + 1'b1;
            end else if (respPop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // register writeback only needs the low half of the port word
    always_ff @(posedge sys_clk) begin
        if (push) begin
            memDest[wrPtr] <= ioInDestReg;
            memData[wrPtr] <= ioInData[dataWidth-1:0];
        end
    end

endmodule

// File: ioStoreQueue.sv
// ioStoreQueue: places store data in port lanes and queues commands until the device grants credits
`timescale 1ns/1ps

module ioStoreQueue import ioCmdPkg::*; (
    input  logic                   sys_clk,
    input  logic                   arstN,
    input  logic                   storePush,
    input  logic [3:0]             cmdOpcode,
    input  logic [dataWidth-1:0]   cmdAddr,
    input  logic [dataWidth-1:0]   cmdData,
    input  logic [regWidth-1:0]    cmdDestReg,
    input  logic                   ioOutCredit,
    output logic                   storeFull,
    output logic [storeCountW-1:0] storeCount,
    output logic                   ioOutStrobe,
    output logic                   ioOutAtomic,
    output logic [regWidth-1:0]    ioOutDestReg,
    output logic [laneCount-1:0]   ioOutByteEn,
    output logic [portWidth-1:0]   ioOutData
);

    logic [portWidth-1:0] laneData;
    logic [laneCount-1:0] laneEn;
    logic [storePtrW-1:0] wrPtr;
    logic [storePtrW-1:0] rdPtr;
    logic                 pop;

    // circular buffer storage
    logic                 memAtomic [storeDepth];
    logic [regWidth-1:0]  memDest   [storeDepth];
    logic [laneCount-1:0] memByteEn [storeDepth];
    logic [portWidth-1:0] memData   [storeDepth];

    // lane placement, unused lanes carry zero
    always_comb begin
        laneData = '0;
        laneEn   = '0;
        case (opSize(cmdOpcode))
            sizeByte: begin
                laneData = portWidth'(cmdData[7:0]) << {cmdAddr[1:0], 3'b000};
                laneEn   = laneCount'(1) << cmdAddr[1:0];
            end
            sizeHalf: begin
                // addr bit 1 picks upper or lower lane pair
                laneData = cmdAddr[1] ? {cmdData, {dataWidth{1'b0}}} : portWidth'(cmdData);
                laneEn   = cmdAddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                // core data is only half a port word
                laneData = portWidth'(cmdData);
                laneEn   = 4'b0011;
            end
        endcase
    end

    assign storeFull = (storeCount == storeCountW'(storeDepth));

    // a credit on an empty queue is simply lost
    assign pop = ioOutCredit && (storeCount != '0);

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            storeCount  <= '0;
            ioOutStrobe <= 1'b0;
        end else begin
            if (storePush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and pop together leave the count alone
            if (storePush && !pop) begin
                storeCount <= storeCount + 1'b1;
            end else if (pop && !storePush) begin
                storeCount <= storeCount - 1'b1;
            end
            ioOutStrobe <= pop;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (storePush) begin
            memAtomic[wrPtr] <= (opClass(cmdOpcode) == classAtomic);
            memDest[wrPtr]   <= cmdDestReg;
            memByteEn[wrPtr] <= laneEn;
            memData[wrPtr]   <= laneData;
        end
        // head entry moves to the device side registers
        if (pop) begin
            ioOutAtomic  <= memAtomic[rdPtr];
            ioOutDestReg <= memDest[rdPtr];
            ioOutByteEn  <= memByteEn[rdPtr];
            ioOutData    <= memData[rdPtr];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# compile and run ioPortTb with Verilator, fail on any step or on a failing test

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f ioPortTop.f --top-module ioPortTb -o simIoPort
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/simIoPort > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
    exit 1
fi
exit 0
